// File: src/framed_link_pkg.sv
// shared widths, lane count, preamble marker and framer states
// for the framed packet link transmitter

package framed_link_pkg;

   // stream word width
   localparam int DATA_W = 64;

   // number of frame inserter lanes, 2, 4 or 8
   localparam int NUM_LANES = 4;
   localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   // marker word sent ahead of every packet
   localparam logic [DATA_W-1:0] PREAMBLE_WORD = 64'hBA5E_BA77_B01D_FACE;

   typedef enum logic [1:0] {
      IDLE     = 2'd0,
      PREAMBLE = 2'd1,
      PASS     = 2'd2,
      TRAILER  = 2'd3
   } frame_state_t;

   // next lane in strict rotation, wraps after the last lane
   function automatic logic [LANE_W-1:0] next_lane(input logic [LANE_W-1:0] lane);
      if (lane == LANE_W'(NUM_LANES - 1))
         return '0;
      return lane + 1'b1;
   endfunction

endpackage

// File: src/packet_dispatch.sv
// packet dispatcher
// steers whole input packets to the frame inserter lanes in strict rotation

module packet_dispatch
   import framed_link_pkg::*;
(
   input  logic                                clk,
   input  logic                                i_rst_n,
   input  logic                                i_clear,
   // input stream
   input  logic [DATA_W-1:0]                   i_tdata,
   input  logic                                i_tlast,
   input  logic                                i_tvalid,
   output logic                                o_tready,
   // per-lane streams
   output logic [NUM_LANES-1:0][DATA_W-1:0]    o_lane_data,
   output logic [NUM_LANES-1:0]                o_lane_last,
   output logic [NUM_LANES-1:0]                o_lane_valid,
   input  logic [NUM_LANES-1:0]                i_lane_ready
);

   logic [LANE_W-1:0] lane_ptr;
   logic              last_accepted;

   // ######################################################################
   // lane pointer
   // ######################################################################

   // a packet only ends on an accepted last word, so it never splits
   assign last_accepted = i_tvalid & o_tready & i_tlast;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         lane_ptr <= '0;
      end else if (i_clear) begin
         lane_ptr <= '0;
      end else if (last_accepted) begin
         lane_ptr <= next_lane(lane_ptr);
      end
   end

   // ######################################################################
   // steering
   // ######################################################################

   // data and last fan out to every lane, valid only to the pointed one
   always_comb begin
      for (int lane = 0; lane < NUM_LANES; lane++) begin
         o_lane_data[lane] = i_tdata;
         o_lane_last[lane] = i_tlast;
      end
   end

   always_comb begin
      o_lane_valid = '0;
      o_lane_valid[lane_ptr] = i_tvalid;
   end

   // only the pointed lane may accept the word
   assign o_tready = i_lane_ready[lane_ptr];

endmodule

// File: src/frame_inserter.sv
// frame inserter for one lane
// adds the preamble word before a packet and the checksum/count trailer after it

module frame_inserter
   import framed_link_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_clear,
   // payload in
   input  logic [DATA_W-1:0] i_tdata,
   input  logic              i_tlast,
   input  logic              i_tvalid,
   output logic              o_tready,
   // framed out
   output logic [DATA_W-1:0] o_tdata,
   output logic              o_tlast,
   output logic              o_tvalid,
   input  logic              i_tready
);

   frame_state_t state;
   frame_state_t next_state;

   logic [DATA_W/2-1:0] checksum;
   logic [DATA_W/2-1:0] word_count;
   logic                in_accepted;

   assign in_accepted = i_tvalid & o_tready;

   // ######################################################################
   // trailer accumulation
   // ######################################################################

   // both fold in one payload word per accepted beat, restart in IDLE
   always_ff @(posedge clk) begin
      if (state == IDLE) begin
         checksum   <= '0;
         word_count <= '0;
      end else if (in_accepted) begin
         checksum   <= checksum ^ i_tdata[DATA_W-1:DATA_W/2] ^ i_tdata[DATA_W/2-1:0];
         word_count <= word_count + 1'b1;
      end
   end

   // ######################################################################
   // framing FSM
   // ######################################################################

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= IDLE;
      end else if (i_clear) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      unique case (state)
         IDLE: begin
            if (i_tvalid)
               next_state = PREAMBLE;
         end
         PREAMBLE: begin
            if (i_tready)
               next_state = PASS;
         end
         PASS: begin
            if (in_accepted && i_tlast)
               next_state = TRAILER;
         end
         TRAILER: begin
            if (i_tready)
               next_state = IDLE;
         end
         default: next_state = IDLE;
      endcase
   end

   // output mux, payload goes straight through in PASS
   always_comb begin
      unique case (state)
         PREAMBLE: o_tdata = PREAMBLE_WORD;
         PASS:     o_tdata = i_tdata;
         TRAILER:  o_tdata = {checksum, word_count};
         default:  o_tdata = '0;
      endcase
   end

   assign o_tvalid = (state == PASS) ? i_tvalid : (state != IDLE);
   assign o_tlast  = (state == TRAILER);

   // back-pressure reaches the input only while passing payload
   assign o_tready = (state == PASS) ? i_tready : 1'b0;

endmodule

// File: src/frame_merge.sv
// frame merger
// drains framed packets from the lanes in dispatch order onto one stream

module frame_merge
   import framed_link_pkg::*;
(
   input  logic                                clk,
   input  logic                                i_rst_n,
   input  logic                                i_clear,
   // per-lane framed streams
   input  logic [NUM_LANES-1:0][DATA_W-1:0]    i_lane_data,
   input  logic [NUM_LANES-1:0]                i_lane_last,
   input  logic [NUM_LANES-1:0]                i_lane_valid,
   output logic [NUM_LANES-1:0]                o_lane_ready,
   // merged output stream
   output logic [DATA_W-1:0]                   o_tdata,
   output logic                                o_tlast,
   output logic                                o_tvalid,
   input  logic                                i_tready
);

   logic [LANE_W-1:0] read_ptr;
   logic              frame_done;

   // ######################################################################
   // read pointer
   // ######################################################################

   // follows the dispatcher rotation so frames leave in arrival order
   assign frame_done = o_tvalid & i_tready & o_tlast;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         read_ptr <= '0;
      end else if (i_clear) begin
         read_ptr <= '0;
      end else if (frame_done) begin
         read_ptr <= next_lane(read_ptr);
      end
   end

   // ######################################################################
   // output select
   // ######################################################################

   assign o_tdata  = i_lane_data[read_ptr];
   assign o_tlast  = i_lane_last[read_ptr];
   assign o_tvalid = i_lane_valid[read_ptr];

   // other lanes stay stalled until their turn comes
   always_comb begin
      o_lane_ready = '0;
      o_lane_ready[read_ptr] = i_tready;
   end

endmodule

// File: src/framed_link.sv
// framed link transmitter top level
// dispatcher, one frame inserter per lane, and the merger

module framed_link
   import framed_link_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_clear,
   // packet input
   input  logic [DATA_W-1:0] i_tdata,
   input  logic              i_tlast,
   input  logic              i_tvalid,
   output logic              o_tready,
   // framed output
   output logic [DATA_W-1:0] o_tdata,
   output logic              o_tlast,
   output logic              o_tvalid,
   input  logic              i_tready
);

   // dispatcher to inserters
   logic [NUM_LANES-1:0][DATA_W-1:0] lane_in_data;
   logic [NUM_LANES-1:0]             lane_in_last;
   logic [NUM_LANES-1:0]             lane_in_valid;
   logic [NUM_LANES-1:0]             lane_in_ready;

   // inserters to merger
   logic [NUM_LANES-1:0][DATA_W-1:0] lane_out_data;
   logic [NUM_LANES-1:0]             lane_out_last;
   logic [NUM_LANES-1:0]             lane_out_valid;
   logic [NUM_LANES-1:0]             lane_out_ready;

   packet_dispatch packet_dispatch_i (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_clear      (i_clear),
      .i_tdata      (i_tdata),
      .i_tlast      (i_tlast),
      .i_tvalid     (i_tvalid),
      .o_tready     (o_tready),
      .o_lane_data  (lane_in_data),
      .o_lane_last  (lane_in_last),
      .o_lane_valid (lane_in_valid),
      .i_lane_ready (lane_in_ready)
   );

   for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
      frame_inserter frame_inserter_i (
         .clk      (clk),
         .i_rst_n  (i_rst_n),
         .i_clear  (i_clear),
         .i_tdata  (lane_in_data[lane]),
         .i_tlast  (lane_in_last[lane]),
         .i_tvalid (lane_in_valid[lane]),
         .o_tready (lane_in_ready[lane]),
         .o_tdata  (lane_out_data[lane]),
         .o_tlast  (lane_out_last[lane]),
         .o_tvalid (lane_out_valid[lane]),
         .i_tready (lane_out_ready[lane])
      );
   end

   frame_merge frame_merge_i (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_clear      (i_clear),
      .i_lane_data  (lane_out_data),
      .i_lane_last  (lane_out_last),
      .i_lane_valid (lane_out_valid),
      .o_lane_ready (lane_out_ready),
      .o_tdata      (o_tdata),
      .o_tlast      (o_tlast),
      .o_tvalid     (o_tvalid),
      .i_tready     (i_tready)
   );

endmodule

// File: bench/framed_link_model.svh
// reference model of the framed link
// expected payload and trailer words built from each accepted input word

`ifndef FRAMED_LINK_MODEL_SVH
`define FRAMED_LINK_MODEL_SVH

// expected words that follow the preamble, oldest first
logic [DATA_W-1:0]   exp_data_q[$];
logic                exp_last_q[$];

// trailer fields of the packet that is still coming in
logic [DATA_W/2-1:0] run_checksum;
logic [DATA_W/2-1:0] run_count;

// upper half xor lower half of one payload word
function automatic logic [DATA_W/2-1:0] fold_halves(input logic [DATA_W-1:0] word);
   return word[DATA_W-1:DATA_W/2] ^ word[DATA_W/2-1:0];
endfunction

// checksum on top, payload word count below
function automatic logic [DATA_W-1:0] trailer_word(
   input logic [DATA_W/2-1:0] checksum,
   input logic [DATA_W/2-1:0] count
);
   return {checksum, count};
endfunction

function automatic void clear_model();
   exp_data_q.delete();
   exp_last_q.delete();
   run_checksum = '0;
   run_count    = '0;
endfunction

// payload goes out unchanged, the trailer follows the last word
function automatic void record_input_word(input logic [DATA_W-1:0] word, input logic last);
   exp_data_q.push_back(word);
   exp_last_q.push_back(1'b0);
   run_checksum = run_checksum ^ fold_halves(word);
   run_count    = run_count + 1;
   if (last) begin
      exp_data_q.push_back(trailer_word(run_checksum, run_count));
      exp_last_q.push_back(1'b1);
      run_checksum = '0;
      run_count    = '0;
   end
endfunction

`endif

// File: bench/framed_link_tb.sv
// testbench for the framed link transmitter
// random packets and back-pressure checked against the reference model

module framed_link_tb
   import framed_link_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD  = 100;
   localparam int NUM_PACKETS = 60;
   // an odd packet count leaves both pointers off lane 0 before the clear
   localparam int CLEAR_AFTER = 31;
   localparam int MAX_LEN     = 16;
   localparam int WAIT_LIMIT  = 200;
   localparam int DRAIN_LIMIT = 2000;

   logic              clk;
   logic              i_rst_n;
   logic              i_clear;
   logic [DATA_W-1:0] i_tdata;
   logic              i_tlast;
   logic              i_tvalid;
   logic              o_tready;
   logic [DATA_W-1:0] o_tdata;
   logic              o_tlast;
   logic              o_tvalid;
   logic              i_tready;

   integer seed;
   int     stall_left;
   int     sent_words;
   int     in_words;
   int     out_words;
   int     frames_out;
   logic   in_frame;

   `include "framed_link_model.svh"

   framed_link framed_link_i (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_clear  (i_clear),
      .i_tdata  (i_tdata),
      .i_tlast  (i_tlast),
      .i_tvalid (i_tvalid),
      .o_tready (o_tready),
      .o_tdata  (o_tdata),
      .o_tlast  (o_tlast),
      .o_tvalid (o_tvalid),
      .i_tready (i_tready)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ####################################################################
   // helpers
   // ####################################################################

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_idle_outputs(input string when);
      assert (!o_tvalid && !o_tlast && !o_tready)
         else abort_run($sformatf("** Error at %0d ns: outputs not idle %s (valid %b last %b ready %b)",
                                  $time, when, o_tvalid, o_tlast, o_tready));
   endtask

   // back-pressure comes in bursts of 1 to 6 stalled cycles
   task automatic next_falling_edge();
      @(negedge clk);
      if (stall_left > 0) begin
         stall_left = stall_left - 1;
      end else if (($random(seed) & 7) == 0) begin
         stall_left = 1 + ($unsigned($random(seed)) % 6);
      end
      i_tready = (stall_left == 0);
   endtask

   task automatic idle_cycles(input int count);
      i_tvalid = 1'b0;
      i_tlast  = 1'b0;
      repeat (count) begin
         @(posedge clk);
         next_falling_edge();
      end
   endtask

   // valid holds with stable data until the link takes the word
   task automatic send_word(input logic [DATA_W-1:0] word, input logic last);
      int   waited;
      logic taken;
      waited   = 0;
      taken    = 1'b0;
      i_tdata  = word;
      i_tlast  = last;
      i_tvalid = 1'b1;
      while (!taken) begin
         @(posedge clk);
         taken = o_tready;
         next_falling_edge();
         waited++;
         assert (taken || waited < WAIT_LIMIT)
            else abort_run("timeout: the link did not accept an input word");
      end
      i_tvalid = 1'b0;
      i_tlast  = 1'b0;
   endtask

   task automatic send_packet(input int len);
      logic [31:0] upper;
      logic [31:0] lower;
      for (int idx = 0; idx < len; idx++) begin
         if (($random(seed) & 3) == 0)
            idle_cycles(1 + ($unsigned($random(seed)) % 3));
         upper = $random(seed);
         lower = $random(seed);
         send_word({upper, lower}, idx == len - 1);
      end
   endtask

   task automatic wait_drained(input int frames, input string what);
      int waited;
      waited = 0;
      while (frames_out < frames || in_frame) begin
         @(posedge clk);
         next_falling_edge();
         waited++;
         assert (waited < DRAIN_LIMIT)
            else abort_run($sformatf("timeout: %s never came out of the link", what));
      end
   endtask

   // synchronous clear while every lane is idle
   task automatic clear_between_packets(input int frames);
      wait_drained(frames, "the frames before the clear");
      i_clear = 1'b1;
      @(posedge clk);
      check_idle_outputs("while i_clear is high");
      next_falling_edge();
      i_clear = 1'b0;
      clear_model();
      @(posedge clk);
      check_idle_outputs("in the cycle after i_clear");
      // the next packet must enter and leave through lane 0
      assert (framed_link_i.packet_dispatch_i.lane_ptr == '0
              && framed_link_i.frame_merge_i.read_ptr == '0)
         else abort_run($sformatf("** Error at %0d ns: lane pointers at %0d and %0d after i_clear",
                                  $time, framed_link_i.packet_dispatch_i.lane_ptr,
                                  framed_link_i.frame_merge_i.read_ptr));
      next_falling_edge();
   endtask

   task automatic check_output_word();
      logic [DATA_W-1:0] exp_word;
      logic              exp_flag;
      if (!in_frame) begin
         assert (o_tdata == PREAMBLE_WORD && !o_tlast)
            else abort_run($sformatf("** Error at %0d ns: frame %0d starts with %h last %b",
                                     $time, frames_out, o_tdata, o_tlast));
         in_frame = 1'b1;
      end else begin
         assert (exp_data_q.size() > 0)
            else abort_run("an output word came out before its input word was accepted");
         exp_word = exp_data_q.pop_front();
         exp_flag = exp_last_q.pop_front();
         assert (o_tdata == exp_word && o_tlast == exp_flag)
            else abort_run($sformatf("** Error at %0d ns: frame %0d got %h last %b, expected %h last %b",
                                     $time, frames_out, o_tdata, o_tlast, exp_word, exp_flag));
         if (o_tlast) begin
            in_frame = 1'b0;
            frames_out++;
         end
      end
      out_words++;
   endtask

   // ####################################################################
   // monitor
   // ####################################################################

   // input side first, a payload word passes through in the same cycle
   always @(posedge clk) begin
      if (i_rst_n) begin
         if (i_tvalid && o_tready) begin
            record_input_word(i_tdata, i_tlast);
            in_words++;
         end
         if (o_tvalid && i_tready)
            check_output_word();
      end
   end

   // ####################################################################
   // stimulus
   // ####################################################################

   initial begin
      int len;
      seed       = 32'h0768_24b6;
      stall_left = 0;
      sent_words = 0;
      in_words   = 0;
      out_words  = 0;
      frames_out = 0;
      in_frame   = 1'b0;
      i_rst_n    = 1'b0;
      i_clear    = 1'b0;
      i_tdata    = '0;
      i_tlast    = 1'b0;
      i_tvalid   = 1'b0;
      i_tready   = 1'b0;
      clear_model();

      repeat (3) begin
         @(posedge clk);
         check_idle_outputs("during reset");
      end
      @(negedge clk);
      i_rst_n = 1'b1;
      @(posedge clk);
      check_idle_outputs("in the first cycle after reset");
      next_falling_edge();

      for (int pkt = 0; pkt < NUM_PACKETS; pkt++) begin
         len = 1 + ($unsigned($random(seed)) % MAX_LEN);
         sent_words += len;
         send_packet(len);
         if (($random(seed) & 3) == 0)
            idle_cycles(1 + ($unsigned($random(seed)) % 4));
         if (pkt == CLEAR_AFTER - 1)
            clear_between_packets(pkt + 1);
      end
      wait_drained(NUM_PACKETS, "the last frames");

      assert (in_words == sent_words)
         else abort_run($sformatf("** Error at %0d ns: %0d input words accepted, %0d sent",
                                  $time, in_words, sent_words));
      assert (out_words == sent_words + 2 * NUM_PACKETS)
         else abort_run($sformatf("** Error at %0d ns: %0d output words, expected %0d",
                                  $time, out_words, sent_words + 2 * NUM_PACKETS));
      if (exp_data_q.size() == 0 && frames_out == NUM_PACKETS) begin
         $display("TEST OK");
         $finish;
      end else begin
         abort_run("the model still holds expected words after the last frame");
      end
   end

endmodule

// File: framed_link.f
+incdir+bench
src/framed_link_pkg.sv
src/packet_dispatch.sv
src/frame_inserter.sv
src/frame_merge.sv
src/framed_link.sv
bench/framed_link_tb.sv

// File: Makefile
# Verilator build and run of the framed link testbench

VERILATOR       ?= verilator
TOP             ?= framed_link_tb
FILELIST        ?= framed_link.f
BUILD_DIR       ?= build
LOG             ?= $(BUILD_DIR)/sim.log
PASS_TEXT       ?= TEST OK
VERILATOR_FLAGS ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
SIM_FLAGS       ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VERILATOR_FLAGS SIM_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
